// File: Makefile
TOP := tb_lsu

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o V$(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir

// File: lsu_assertions.sv
// protocol assertions for the load/store unit, bound into lsu_top
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module lsu_assertions (
  input logic                   clk,
  input logic                   rst_n,
  input logic                   data_req_i,
  input logic                   data_gnt_i,
  input logic                   data_rvalid_i,
  input logic                   busy_i,
  input logic                   lsu_ready_ex_i,
  input logic [`LSU_DATA_W-1:0] addr_i
);

  int fail_cnt = 0;  // assertion failures so far

  rvalid_needs_busy: assert property (@(posedge clk) disable iff (!rst_n)
    data_rvalid_i |-> busy_i)
  else
  begin
    fail_cnt++;
    $error("rvalid while the unit is idle");
  end

  addr_known: assert property (@(posedge clk) disable iff (!rst_n)
    data_req_i |-> !$isunknown(addr_i))
  else
  begin
    fail_cnt++;
    $error("unknown address on a request");
  end

  // ex must wait while the request is not granted
  ex_held: assert property (@(posedge clk) disable iff (!rst_n)
    (data_req_i && !data_gnt_i) |-> !lsu_ready_ex_i)
  else
  begin
    fail_cnt++;
    $error("ex ready without grant");
  end

endmodule

bind lsu_top lsu_assertions i_assertions (
  .clk            (clk),
  .rst_n          (rst_n),
  .data_req_i     (data_req_o),
  .data_gnt_i     (data_gnt_i),
  .data_rvalid_i  (data_rvalid_i),
  .busy_i         (busy_o),
  .lsu_ready_ex_i (lsu_ready_ex_o),
  .addr_i         (mem_req_o.addr)
);

`default_nettype wire

// File: lsu_checker.sv
// reference model of the load/store unit
// watches the DUT ports mid-cycle, queues grant contexts and counts mismatches
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module lsu_checker (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_ex_pkg::ex_req_t    ex_req_i,
  input  logic                   ex_valid_i,
  input  logic                   data_req_i,
  input  lsu_mem_pkg::mem_req_t  mem_req_i,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_ex_i,
  input  logic                   load_err_i,
  input  logic                   store_err_i,
  input  logic                   lsu_ready_ex_i,
  input  logic                   lsu_ready_wb_i,
  input  logic                   busy_i,
  output int                     errors_o
);

  import lsu_ex_pkg::*;
  import lsu_mem_pkg::*;

  resp_ctx_t   ctx_q[$];       // granted, waiting for rvalid
  logic [31:0] hold_exp = '0;  // last load result
  logic        in_flight = 1'b0;
  lsu_state_e  st = ST_IDLE;   // expected controller state in this cycle
  int          errors = 0;

  assign errors_o = errors;

  task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
    if (exp !== got)
    begin
      errors++;
      $display("CHECK FAILED t=%0t %s expected %h got %h", $time, name, exp, got);
    end
  endtask

  task automatic complain(input string what);
    errors++;
    $display("ERROR t=%0t %s", $time, what);
  endtask

  function automatic logic [3:0] expected_be(input mem_size_e s, input logic [1:0] k);
    logic [3:0] be;
    case (s)
      LSU_WORD: be = 4'b1111;
      LSU_HALF: be = 4'b0011 << k;
      default:  be = 4'b0001 << k;  // byte and code 11
    endcase
    return be;
  endfunction

  // rotate left by whole bytes
  function automatic logic [31:0] rotl_bytes(input logic [31:0] w, input logic [1:0] n);
    logic [63:0] d;
    d = {w, w};
    return d[63 - 8 * int'(n) -: 32];
  endfunction

  function automatic logic [31:0] load_value(input resp_ctx_t c, input logic [31:0] rd);
    logic [31:0] sh;
    logic [31:0] res;
    logic        msb;
    logic        fill;
    sh  = rd >> (8 * int'(c.offset));
    msb = (c.size == LSU_HALF) ? sh[15] : sh[7];
    if (c.ext == EXT_ZERO)
      fill = 1'b0;
    else if (c.ext == EXT_ONES)
      fill = 1'b1;
    else
      fill = msb;                   // sign, code 11 too
    case (c.size)
      LSU_WORD: res = rd;
      LSU_HALF: res = {{16{fill}}, sh[15:0]};
      default:  res = {{24{fill}}, sh[7:0]};
    endcase
    return res;
  endfunction

  ////////////////////////////////////////
  // per-cycle comparison at negedge
  ////////////////////////////////////////
  always @(negedge clk)
  begin : check
    logic        hs;
    logic        req_exp;
    logic [31:0] addr;
    logic [31:0] exp;
    resp_ctx_t   c;
    resp_ctx_t   nc;
    if (!rst_n)
    begin
      ctx_q.delete();
      hold_exp  = '0;
      in_flight = 1'b0;
      st        = ST_IDLE;
    end
    else
    begin
      hs   = data_req_i && data_gnt_i;
      addr = ex_req_i.use_incr ? ex_req_i.op_a + ex_req_i.op_b : ex_req_i.op_a;

      // control, requests go out from idle or with the rvalid of a plain wait
      case (st)
        ST_IDLE:        req_exp = ex_req_i.req;
        ST_WAIT_RVALID: req_exp = ex_req_i.req && data_rvalid_i;
        default:        req_exp = 1'b0;  // ex stalled
      endcase
      compare("data_req_o", {31'b0, req_exp}, {31'b0, data_req_i});
      compare("lsu_ready_ex_o", {31'b0, !(req_exp && !data_gnt_i)},
              {31'b0, lsu_ready_ex_i});
      compare("lsu_ready_wb_o", {31'b0, !(st == ST_WAIT_RVALID && !data_rvalid_i)},
              {31'b0, lsu_ready_wb_i});
      if ((in_flight || hs) && !busy_i)
        complain("busy_o is low while an access is in flight");
      compare("load_err_o", {31'b0, data_gnt_i && data_err_i && !ex_req_i.we},
              {31'b0, load_err_i});
      compare("store_err_o", {31'b0, data_gnt_i && data_err_i && ex_req_i.we},
              {31'b0, store_err_i});

      // request path
      if (data_req_i)
      begin
        compare("mem_req_o.addr", addr, mem_req_i.addr);
        compare("mem_req_o.we", {31'b0, ex_req_i.we}, {31'b0, mem_req_i.we});
        compare("mem_req_o.be", {28'b0, expected_be(ex_req_i.size, addr[1:0])},
                {28'b0, mem_req_i.be});
        compare("mem_req_o.wdata",
                rotl_bytes(ex_req_i.wdata, addr[1:0] - ex_req_i.reg_offset), mem_req_i.wdata);
      end

      // response, store rvalid shows live junk and is skipped
      if (data_rvalid_i)
      begin
        if (!in_flight || ctx_q.size() == 0)
          complain("rvalid arrived with no access outstanding");
        else
        begin
          c = ctx_q.pop_front();
          if (!c.we)
          begin
            exp = load_value(c, data_rdata_i);
            compare("data_rdata_ex_o", exp, data_rdata_ex_i);
            hold_exp = exp;
          end
        end
        in_flight = 1'b0;
      end
      else
        compare("data_rdata_ex_o (held)", hold_exp, data_rdata_ex_i);

      if (hs)
      begin
        nc.size   = ex_req_i.size;
        nc.offset = addr[1:0];
        nc.ext    = ex_req_i.ext;
        nc.we     = ex_req_i.we;
        ctx_q.push_back(nc);
        in_flight = 1'b1;
      end

      // controller state for the next cycle
      case (st)
        ST_IDLE, ST_WAIT_RVALID:
        begin
          if (hs)
            st = ex_valid_i ? ST_WAIT_RVALID : ST_WAIT_RVALID_EX_STALL;
          else if (data_rvalid_i)
            st = ST_IDLE;
        end
        ST_WAIT_RVALID_EX_STALL:
        begin
          if (data_rvalid_i)
            st = ex_valid_i ? ST_IDLE : ST_IDLE_EX_STALL;
          else if (ex_valid_i)
            st = ST_WAIT_RVALID;
        end
        default:
        begin
          if (ex_valid_i)
            st = ST_IDLE;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// File: lsu_defines.svh
// width constants for the load/store unit
// include before any package or module that sizes ports or fields with them
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// data bus and address width, fixed by the 32-bit ISA
`define LSU_DATA_W 32

// one enable per byte lane
`define LSU_BE_W 4

// byte offset inside a word, log2 of the lane count
`define LSU_OFF_W 2

`endif

// File: lsu_ex_pkg.sv
// execute-side types of the load/store unit
// size and extension codes plus the request bundle from the ex stage
`include "lsu_defines.svh"
`default_nettype none

package lsu_ex_pkg;

  // access size, code 11 decodes as byte
  typedef enum logic [1:0] {
    LSU_WORD = 2'b00,
    LSU_HALF = 2'b01,
    LSU_BYTE = 2'b10
  } mem_size_e;

  // load extension, code 11 behaves like sign
  typedef enum logic [1:0] {
    EXT_ZERO = 2'b00,
    EXT_SIGN = 2'b01,
    EXT_ONES = 2'b10
  } ext_mode_e;

  typedef struct packed {
    logic                   req;         // access request
    logic                   we;          // store when set
    mem_size_e              size;
    ext_mode_e              ext;
    logic [`LSU_OFF_W-1:0]  reg_offset;  // byte offset of store data in the register
    logic [`LSU_DATA_W-1:0] wdata;
    logic [`LSU_DATA_W-1:0] op_a;        // base operand
    logic [`LSU_DATA_W-1:0] op_b;        // increment operand
    logic                   use_incr;    // address is op_a + op_b
  } ex_req_t;

endpackage

`default_nettype wire

// File: lsu_fsm.sv
// request controller of the load/store unit
// one outstanding access, tracks ex stalls, drives ready, busy and error flags
`timescale 1ns/1ps
`default_nettype none

module lsu_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic req_i,           // ex stage wants an access
  input  logic we_i,            // access is a store
  input  logic ex_valid_i,      // low while ex stage is stalled
  input  logic data_gnt_i,
  input  logic data_rvalid_i,
  input  logic data_err_i,
  output logic data_req_o,
  output logic lsu_ready_ex_o,  // ex stage may move on
  output logic lsu_ready_wb_o,  // wb stage may move on
  output logic load_err_o,
  output logic store_err_o,
  output logic busy_o
);

  import lsu_mem_pkg::*;

  lsu_state_e state_q, state_d;

  ////////////////////////////////////////
  // next state and outputs
  ////////////////////////////////////////
  always_comb
  begin
    state_d        = state_q;
    data_req_o     = 1'b0;
    lsu_ready_ex_o = 1'b1;
    lsu_ready_wb_o = 1'b1;

    case (state_q)
      ST_IDLE:
      begin
        data_req_o = req_i;
        if (req_i && !data_gnt_i)
          lsu_ready_ex_o = 1'b0;        // hold ex until granted
        if (req_i && data_gnt_i)
        begin
          if (ex_valid_i)
            state_d = ST_WAIT_RVALID;
          else
            state_d = ST_WAIT_RVALID_EX_STALL;
        end
      end

      // wb waits for the data, a new request may go out with rvalid
      ST_WAIT_RVALID:
      begin
        lsu_ready_wb_o = data_rvalid_i;
        if (data_rvalid_i)
        begin
          data_req_o = req_i;
          if (req_i && data_gnt_i)
          begin
            if (ex_valid_i)
              state_d = ST_WAIT_RVALID;
            else
              state_d = ST_WAIT_RVALID_EX_STALL;
          end
          else
          begin
            if (req_i)
              lsu_ready_ex_o = 1'b0;    // retried from idle
            state_d = ST_IDLE;
          end
        end
      end

      // ex stalled at grant, no new request here
      ST_WAIT_RVALID_EX_STALL:
      begin
        if (data_rvalid_i)
        begin
          if (ex_valid_i)
            state_d = ST_IDLE;
          else
            state_d = ST_IDLE_EX_STALL;
        end
        else if (ex_valid_i)
          state_d = ST_WAIT_RVALID;     // stall gone, back to the normal wait
      end

      ST_IDLE_EX_STALL:
      begin
        if (ex_valid_i)
          state_d = ST_IDLE;
      end

      default:
      begin
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      state_q <= ST_IDLE;
    else
      state_q <= state_d;
  end

  // bus errors come with the grant
  assign load_err_o  = data_gnt_i && data_err_i && !we_i;
  assign store_err_o = data_gnt_i && data_err_i && we_i;

  assign busy_o = (state_q != ST_IDLE) || data_req_o;

endmodule

`default_nettype wire

// File: lsu_mem_pkg.sv
// memory-side types of the load/store unit
// request bundle to data memory, grant-time context and controller states
`include "lsu_defines.svh"
`default_nettype none

package lsu_mem_pkg;

  import lsu_ex_pkg::*;

  // request towards the data memory
  typedef struct packed {
    logic [`LSU_DATA_W-1:0] addr;
    logic                   we;
    logic [`LSU_BE_W-1:0]   be;     // byte lane enables
    logic [`LSU_DATA_W-1:0] wdata;  // already rotated to the lanes
  } mem_req_t;

  // what the response needs to know about its request
  typedef struct packed {
    mem_size_e             size;
    logic [`LSU_OFF_W-1:0] offset;  // low address bits at grant
    ext_mode_e             ext;
    logic                  we;      // stores do not update the load result
  } resp_ctx_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_RVALID,
    ST_WAIT_RVALID_EX_STALL,
    ST_IDLE_EX_STALL
  } lsu_state_e;

endpackage

`default_nettype wire

// File: lsu_rdata_align.sv
// load data path of the load/store unit
// picks the addressed lanes, extends them and holds the last load result
// output is live during rvalid, the held value otherwise
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module lsu_rdata_align (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lsu_mem_pkg::resp_ctx_t ctx_i,            // context of the outstanding access
  input  logic                   data_rvalid_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,     // raw word from memory
  output logic [`LSU_DATA_W-1:0] data_rdata_ex_o   // result to ex stage
);

  import lsu_ex_pkg::*;

  logic [7:0]             rdata_b;    // selected byte
  logic [15:0]            rdata_h;    // selected halfword
  logic [`LSU_DATA_W-1:0] rdata_ext;  // extended result
  logic [`LSU_DATA_W-1:0] rdata_q;    // last load result

  // fill bit for the upper part of a short load
  function automatic logic fill_bit(input ext_mode_e mode, input logic msb);
    logic fill;
    case (mode)
      EXT_ZERO: fill = 1'b0;
      EXT_ONES: fill = 1'b1;
      default:  fill = msb;  // sign, code 11 too
    endcase
    return fill;
  endfunction

  ////////////////////////////////////////
  // lane select
  ////////////////////////////////////////
  always_comb
  begin
    case (ctx_i.offset)
      2'b00:   rdata_b = data_rdata_i[7:0];
      2'b01:   rdata_b = data_rdata_i[15:8];
      2'b10:   rdata_b = data_rdata_i[23:16];
      default: rdata_b = data_rdata_i[31:24];
    endcase
  end

  always_comb
  begin
    case (ctx_i.offset)
      2'b00:   rdata_h = data_rdata_i[15:0];
      2'b01:   rdata_h = data_rdata_i[23:8];
      2'b10:   rdata_h = data_rdata_i[31:16];
      default: rdata_h = {data_rdata_i[7:0], data_rdata_i[31:24]};  // wraps to lane 0
    endcase
  end

  // size mux with extension, words pass untouched
  always_comb
  begin
    case (ctx_i.size)
      LSU_WORD: rdata_ext = data_rdata_i;
      LSU_HALF: rdata_ext = {{16{fill_bit(ctx_i.ext, rdata_h[15])}}, rdata_h};
      default:  rdata_ext = {{24{fill_bit(ctx_i.ext, rdata_b[7])}}, rdata_b};
    endcase
  end

  // only loads update the hold register
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      rdata_q <= '0;
    else if (data_rvalid_i && !ctx_i.we)
      rdata_q <= rdata_ext;
  end

  assign data_rdata_ex_o = data_rvalid_i ? rdata_ext : rdata_q;  // bypass in the rvalid cycle

endmodule

`default_nettype wire

// File: lsu_req_path.sv
// request side of the load/store unit
// address generation, byte enables and store data rotation
// purely combinational, memory sees it in the same cycle as the ex request
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module lsu_req_path (
  input  lsu_ex_pkg::ex_req_t   ex_req_i,       // request from ex stage
  output lsu_mem_pkg::mem_req_t mem_req_o,      // request to data memory
  output logic [`LSU_OFF_W-1:0] addr_offset_o   // byte offset, to the context register
);

  import lsu_ex_pkg::*;

  logic [`LSU_DATA_W-1:0] data_addr;
  logic [`LSU_OFF_W-1:0]  wdata_rot;   // lanes to rotate left
  logic [`LSU_BE_W-1:0]   data_be;
  logic [`LSU_DATA_W-1:0] data_wdata;

  // base or base + offset addressing
  assign data_addr     = ex_req_i.use_incr ? (ex_req_i.op_a + ex_req_i.op_b) : ex_req_i.op_a;
  assign addr_offset_o = data_addr[`LSU_OFF_W-1:0];

  ////////////////////////////////////////
  // byte enables
  ////////////////////////////////////////
  always_comb
  begin
    case (ex_req_i.size)
      LSU_WORD:
      begin
        case (addr_offset_o)
          2'b00:   data_be = 4'b1111;
          2'b01:   data_be = 4'b1110;  // unaligned word, upper lanes only
          2'b10:   data_be = 4'b1100;
          default: data_be = 4'b1000;
        endcase
      end
      LSU_HALF:
      begin
        case (addr_offset_o)
          2'b00:   data_be = 4'b0011;
          2'b01:   data_be = 4'b0110;
          2'b10:   data_be = 4'b1100;
          default: data_be = 4'b1000;  // clipped at lane 3
        endcase
      end
      default:                         // byte, size code 11 too
      begin
        data_be = 4'b0001 << addr_offset_o;
      end
    endcase
  end

  ////////////////////////////////////////
  // store data lane alignment
  ////////////////////////////////////////
  // register byte reg_offset has to land on lane addr_offset
  assign wdata_rot = addr_offset_o - ex_req_i.reg_offset;

  always_comb
  begin
    case (wdata_rot)
      2'b00:   data_wdata = ex_req_i.wdata;
      2'b01:   data_wdata = {ex_req_i.wdata[23:0], ex_req_i.wdata[31:24]};
      2'b10:   data_wdata = {ex_req_i.wdata[15:0], ex_req_i.wdata[31:16]};
      default: data_wdata = {ex_req_i.wdata[7:0], ex_req_i.wdata[31:8]};
    endcase
  end

  always_comb
  begin
    mem_req_o.addr  = data_addr;
    mem_req_o.we    = ex_req_i.we;
    mem_req_o.be    = data_be;
    mem_req_o.wdata = data_wdata;
  end

endmodule

`default_nettype wire

// File: lsu_resp_ctx.sv
// access context captured at grant time
// steers the read aligner while the access is outstanding
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module lsu_resp_ctx (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   data_gnt_i,     // request accepted this cycle
  input  lsu_ex_pkg::ex_req_t    ex_req_i,
  input  logic [`LSU_OFF_W-1:0]  addr_offset_i,  // low address bits from the request path
  output lsu_mem_pkg::resp_ctx_t ctx_o           // valid from grant+1 through rvalid
);

  import lsu_mem_pkg::*;

  resp_ctx_t ctx_d;

  always_comb
  begin
    ctx_d.size   = ex_req_i.size;
    ctx_d.offset = addr_offset_i;
    ctx_d.ext    = ex_req_i.ext;
    ctx_d.we     = ex_req_i.we;
  end

  // a grant in the rvalid cycle overwrites the old context only after rvalid used it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      ctx_o <= '0;
    else if (data_gnt_i)
      ctx_o <= ctx_d;
  end

endmodule

`default_nettype wire

// File: lsu_top.sv
// load/store unit top level
// request path, grant context, read aligner and controller wired together
// sits between the ex stage and a req/gnt/rvalid data memory port
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module lsu_top (
  input  logic                   clk,
  input  logic                   rst_n,
  // ex stage side
  input  lsu_ex_pkg::ex_req_t    ex_req_i,
  input  logic                   ex_valid_i,
  output logic [`LSU_DATA_W-1:0] data_rdata_ex_o,
  output logic                   lsu_ready_ex_o,
  output logic                   lsu_ready_wb_o,
  output logic                   busy_o,
  // data memory side
  output logic                   data_req_o,
  output lsu_mem_pkg::mem_req_t  mem_req_o,
  input  logic                   data_gnt_i,
  input  logic                   data_rvalid_i,
  input  logic                   data_err_i,
  input  logic [`LSU_DATA_W-1:0] data_rdata_i,
  // exceptions
  output logic                   load_err_o,
  output logic                   store_err_o
);

  import lsu_mem_pkg::*;

  logic [`LSU_OFF_W-1:0] addr_offset;  // request path -> context
  resp_ctx_t             ctx;          // context -> aligner

  lsu_req_path i_req_path (
    .ex_req_i      (ex_req_i),
    .mem_req_o     (mem_req_o),
    .addr_offset_o (addr_offset)
  );

  lsu_resp_ctx i_resp_ctx (
    .clk           (clk),
    .rst_n         (rst_n),
    .data_gnt_i    (data_gnt_i),
    .ex_req_i      (ex_req_i),
    .addr_offset_i (addr_offset),
    .ctx_o         (ctx)
  );

  lsu_rdata_align i_rdata_align (
    .clk             (clk),
    .rst_n           (rst_n),
    .ctx_i           (ctx),
    .data_rvalid_i   (data_rvalid_i),
    .data_rdata_i    (data_rdata_i),
    .data_rdata_ex_o (data_rdata_ex_o)
  );

  lsu_fsm i_fsm (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_i          (ex_req_i.req),
    .we_i           (ex_req_i.we),
    .ex_valid_i     (ex_valid_i),
    .data_gnt_i     (data_gnt_i),
    .data_rvalid_i  (data_rvalid_i),
    .data_err_i     (data_err_i),
    .data_req_o     (data_req_o),
    .lsu_ready_ex_o (lsu_ready_ex_o),
    .lsu_ready_wb_o (lsu_ready_wb_o),
    .load_err_o     (load_err_o),
    .store_err_o    (store_err_o),
    .busy_o         (busy_o)
  );

endmodule

`default_nettype wire

// File: tb_lsu.sv
// testbench top for the load/store unit
// random ex requests from an lcg, a req/gnt/rvalid memory responder,
// a cycle limit and the closing verdict; comparing lives in lsu_checker
`timescale 1ns/1ps
`include "lsu_defines.svh"
`default_nettype none

module tb_lsu;

  import lsu_ex_pkg::*;
  import lsu_mem_pkg::*;

  localparam int N_ACCESS   = 400;
  localparam int MAX_CYCLES = N_ACCESS * 10 + 50;  // worst case per access plus reset slack

  logic                   clk = 1'b0;
  logic                   rst_n;
  ex_req_t                ex_req = '0;
  logic                   ex_valid = 1'b0;
  logic                   data_req;
  mem_req_t               mem_req;
  logic                   data_gnt;
  logic                   data_rvalid = 1'b0;
  logic                   data_err;
  logic [`LSU_DATA_W-1:0] data_rdata = '0;
  logic [`LSU_DATA_W-1:0] rdata_ex;
  logic                   load_err, store_err, ready_ex, ready_wb, busy;

  logic        err_armed = 1'b0;    // next grant carries a bus error
  logic        outstanding = 1'b0;  // granted, rvalid not seen yet
  logic [31:0] seed = 32'd75128;
  int          gnt_wait = 0;        // cycles of req before memory grants
  int          rv_left = 0;         // edges left until rvalid
  int          n_done = 0;          // accepted accesses
  int          cycles = 0;
  int          check_errs;
  int          total_errs;
  logic        timed_out;

  always #10 clk = ~clk;  // 20 ns period

  // memory grants only with a request and with nothing else outstanding
  assign data_gnt = data_req && (gnt_wait == 0) && (!outstanding || data_rvalid);
  assign data_err = data_gnt && err_armed;

  lsu_top i_dut (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_req_i        (ex_req),
    .ex_valid_i      (ex_valid),
    .data_rdata_ex_o (rdata_ex),
    .lsu_ready_ex_o  (ready_ex),
    .lsu_ready_wb_o  (ready_wb),
    .busy_o          (busy),
    .data_req_o      (data_req),
    .mem_req_o       (mem_req),
    .data_gnt_i      (data_gnt),
    .data_rvalid_i   (data_rvalid),
    .data_err_i      (data_err),
    .data_rdata_i    (data_rdata),
    .load_err_o      (load_err),
    .store_err_o     (store_err)
  );

  lsu_checker i_checker (
    .clk             (clk),
    .rst_n           (rst_n),
    .ex_req_i        (ex_req),
    .ex_valid_i      (ex_valid),
    .data_req_i      (data_req),
    .mem_req_i       (mem_req),
    .data_gnt_i      (data_gnt),
    .data_rvalid_i   (data_rvalid),
    .data_err_i      (data_err),
    .data_rdata_i    (data_rdata),
    .data_rdata_ex_i (rdata_ex),
    .load_err_i      (load_err),
    .store_err_i     (store_err),
    .lsu_ready_ex_i  (ready_ex),
    .lsu_ready_wb_i  (ready_wb),
    .busy_i          (busy),
    .errors_o        (check_errs)
  );

  // plain 32-bit lcg, upper bits are the useful ones
  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  // one random ex request, addresses naturally aligned per size
  function automatic ex_req_t random_request();
    ex_req_t     r;
    logic [31:0] v;
    v            = lcg_next();
    r.req        = (v[31:30] != 2'b00);  // about 3 of 4 cycles
    r.we         = v[29];
    r.size       = mem_size_e'(v[28:27]);
    r.ext        = ext_mode_e'(v[26:25]);
    r.reg_offset = v[24:23];
    r.use_incr   = v[22];
    r.wdata      = lcg_next();
    r.op_a       = lcg_next();
    r.op_b       = lcg_next();
    if (r.size == LSU_WORD)
    begin
      r.op_a[1:0] = 2'b00;
      r.op_b[1:0] = 2'b00;
    end
    else if (r.size == LSU_HALF)
    begin
      r.op_a[0] = 1'b0;
      r.op_b[0] = 1'b0;
    end
    return r;
  endfunction

  ////////////////////////////////////////
  // stimulus and memory responder
  ////////////////////////////////////////
  always @(posedge clk)
  begin : drive
    logic        hs;
    logic [31:0] v;
    logic [31:0] w;
    int          cnt;
    int          done_next;
    if (rst_n)
    begin
      hs        = data_req && data_gnt;  // handshake in the ending cycle
      v         = lcg_next();
      w         = lcg_next();
      done_next = n_done + (hs ? 1 : 0);
      n_done   <= done_next;
      ex_valid <= (v[31:28] < 4'd13);    // ~80 %
      err_armed <= (v[15:0] < 16'd3277); // ~5 %

      // request held until granted
      if (hs || !ex_req.req)
      begin
        if (done_next >= N_ACCESS)
          ex_req <= '0;
        else
          ex_req <= random_request();
      end

      if (hs)
        gnt_wait <= int'(w[31:30]);      // 0..3 for the next request
      else if (data_req && gnt_wait > 0)
        gnt_wait <= gnt_wait - 1;

      cnt = hs ? 1 + (int'(v[27:26]) % 3) : rv_left;  // latency 1..3
      data_rvalid <= (cnt == 1);
      rv_left     <= (cnt > 1) ? cnt - 1 : 0;
      data_rdata  <= w;

      if (hs)
        outstanding <= 1'b1;
      else if (data_rvalid)
        outstanding <= 1'b0;
    end
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;
    while (!(n_done >= N_ACCESS && !outstanding && !data_rvalid) && cycles < MAX_CYCLES)
      @(posedge clk);
    repeat (2) @(posedge clk);  // let the checker see the last cycle
    timed_out = (cycles >= MAX_CYCLES);
    if (timed_out)
      $display("timeout: only %0d of %0d accesses done after %0d cycles",
               n_done, N_ACCESS, cycles);
    total_errs = check_errs + i_dut.i_assertions.fail_cnt + (timed_out ? 1 : 0);
    $display("errors: %0d check mismatches, %0d assertion failures, %0d timeouts, %0d total",
             check_errs, i_dut.i_assertions.fail_cnt, timed_out ? 1 : 0, total_errs);
    if (total_errs == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+.
lsu_ex_pkg.sv
lsu_mem_pkg.sv
lsu_req_path.sv
lsu_resp_ctx.sv
lsu_rdata_align.sv
lsu_fsm.sv
lsu_top.sv
lsu_checker.sv
lsu_assertions.sv
tb_lsu.sv
